/* regblk_top.f */
design/regblk_bus_pkg.sv
design/regblk_map_pkg.sv
design/regblk_decode.sv
design/regblk_fields.sv
design/regblk_result.sv
design/regblk_top.sv
verif/regblk_tb_checks.sv
verif/regblk_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, then judge the log.
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f regblk_top.f --top-module regblk_tb \
  -o regblk_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/regblk_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1 || grep -q "all tests passed" sim.log || exit 1

/* verif/regblk_tb.sv */
module regblk_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TXN   = 49;
  localparam int MAX_STALL = 8;
  localparam int RESET_CYC = 16;
  localparam int BURST_CYC = 300;  // Long enough to saturate the counter.
  localparam int LIMIT     = NUM_TXN * (4 + MAX_STALL) + RESET_CYC + BURST_CYC + 200;

  logic clk = 1'b0;
  logic i_rst_n;
  regblk_bus_pkg::aw_t     i_aw;
  regblk_bus_pkg::w_t      i_w;
  regblk_bus_pkg::ar_t     i_ar;
  logic                    i_bready;
  logic                    i_rready;
  logic                    o_awready;
  logic                    o_wready;
  logic                    o_arready;
  regblk_bus_pkg::b_t      o_b;
  regblk_bus_pkg::r_t      o_r;
  regblk_map_pkg::status_t i_status;
  regblk_map_pkg::irq_t    i_irq_set;
  logic                    i_event;
  regblk_map_pkg::ctrl_t   o_ctrl;
  logic                    o_irq;
  regblk_map_pkg::cmd_t    o_cmd_trigger;
  logic                    failed;
  logic                    irq_hold = 1'b0;
  logic                    event_hold = 1'b0;
  int                      b_stall = 0;
  int                      r_stall = 0;
  int                      cycles = 0;
  logic [31:0]             rnd;
  logic [31:0]             txn_rnd;

  always #4 clk = ~clk;

  regblk_top dut0 (.*);

  regblk_tb_checks checks0 (
    .clk (clk), .i_rst_n (i_rst_n), .i_aw (i_aw), .i_w (i_w), .i_ar (i_ar),
    .i_bready (i_bready), .i_rready (i_rready), .i_awready (o_awready),
    .i_wready (o_wready), .i_arready (o_arready), .i_b (o_b), .i_r (o_r),
    .i_status (i_status), .i_irq_set (i_irq_set), .i_event (i_event), .i_ctrl (o_ctrl),
    .i_irq (o_irq), .i_cmd_trigger (o_cmd_trigger), .o_failed (failed)
  );

  // Returns at acceptance, so the next request meets a pending response.
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(posedge clk);
    i_aw <= {1'b1, addr};
    i_w  <= {1'b1, data, strb};
    do @(negedge clk); while (!(o_awready && o_wready));
    @(posedge clk);  // Accepting edge.
    i_aw.valid <= 1'b0;
    i_w.valid  <= 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr);
    @(posedge clk);
    i_ar <= {1'b1, addr};
    do @(negedge clk); while (!o_arready);
    @(posedge clk);
    i_ar.valid <= 1'b0;
  endtask

  // Hardware inputs and ready stalls.
  always @(posedge clk) begin
    rnd = $urandom;
    if (rnd[7:4] == 4'h0) i_status <= rnd[31:16];
    i_irq_set <= irq_hold ? 4'hA : ((rnd[10:8] == 3'd0) ? rnd[15:12] : 4'h0);
    i_event   <= event_hold || (rnd[2:1] == 2'd0);
    if (b_stall != 0) begin
      b_stall  <= b_stall - 1;
      i_bready <= 1'b0;
    end else begin
      i_bready <= 1'b1;
      b_stall  <= int'($urandom_range(0, MAX_STALL));
    end
    if (r_stall != 0) begin
      r_stall  <= r_stall - 1;
      i_rready <= 1'b0;
    end else begin
      i_rready <= 1'b1;
      r_stall  <= int'($urandom_range(0, MAX_STALL));
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("Timeout after %0d cycles without finishing.", LIMIT);
      $display("tests failed");
      $fatal(1, "run stopped");
    end
  end

  always @(posedge failed) begin
    $display("tests failed");
    $fatal(1, "check failure");
  end

  initial begin
    rnd = $urandom(32'hc95e2959);
    i_rst_n <= 1'b0;
    i_aw <= '0;
    i_w <= '0;
    i_ar <= '0;
    i_bready <= 1'b0;
    i_rready <= 1'b0;
    i_status <= 16'h1234;
    i_irq_set <= '0;
    i_event <= 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    i_rst_n <= 1'b1;
    read_reg(8'h00);
    repeat (6) begin
      write_reg(8'h00, $urandom, 4'($urandom));
      read_reg(8'h00);
    end
    repeat (3) begin
      write_reg(8'h0C, $urandom, 4'($urandom));
      read_reg(8'h0C);
    end
    repeat (3) read_reg(8'h04);
    write_reg(8'h18, 32'h1, 4'hF);  // Unmapped.
    write_reg(8'h02, 32'hFFFF_FFFF, 4'hF);  // Misaligned, CTRL keeps its value.
    read_reg(8'h40);
    read_reg(8'h05);
    write_reg(8'h0C, 32'hF, 4'h1);  // Unmask every interrupt.
    read_reg(8'h08);
    write_reg(8'h08, 32'hF, 4'hF);
    irq_hold <= 1'b1;
    write_reg(8'h08, 32'hF, 4'hF);
    irq_hold <= 1'b0;
    read_reg(8'h08);
    repeat (3) write_reg(8'h10, $urandom, 4'hF);
    read_reg(8'h10);
    repeat (3) read_reg(8'h14);
    event_hold <= 1'b1;
    repeat (BURST_CYC) @(posedge clk);
    read_reg(8'h14);  // Saturated, with an event in the read cycle.
    read_reg(8'h14);
    event_hold <= 1'b0;
    read_reg(8'h14);
    repeat (8) begin
      txn_rnd = $urandom;
      if (txn_rnd[0]) write_reg({3'b000, txn_rnd[4:2], 2'b00}, $urandom, txn_rnd[11:8]);
      else read_reg({3'b000, txn_rnd[4:2], 2'b00});
    end
    do @(negedge clk); while (o_b.valid || o_r.valid);  // Last response taken.
    repeat (4) @(posedge clk);
    if (failed) begin
      $display("tests failed");
      $fatal(1, "check failure");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* verif/regblk_tb_checks.sv */
module regblk_tb_checks (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  regblk_bus_pkg::aw_t     i_aw,
  input  regblk_bus_pkg::w_t      i_w,
  input  regblk_bus_pkg::ar_t     i_ar,
  input  logic                    i_bready,
  input  logic                    i_rready,
  input  logic                    i_awready,
  input  logic                    i_wready,
  input  logic                    i_arready,
  input  regblk_bus_pkg::b_t      i_b,
  input  regblk_bus_pkg::r_t      i_r,
  input  regblk_map_pkg::status_t i_status,
  input  regblk_map_pkg::irq_t    i_irq_set,
  input  logic                    i_event,
  input  regblk_map_pkg::ctrl_t   i_ctrl,
  input  logic                    i_irq,
  input  regblk_map_pkg::cmd_t    i_cmd_trigger,
  output logic                    o_failed
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0] m_ctrl;
  logic [3:0]  m_irq_st;
  logic [3:0]  m_irq_en;
  logic [3:0]  m_cmd;
  logic [7:0]  m_count;
  logic        m_bvalid;
  logic [1:0]  m_bresp;
  logic        m_rvalid;
  logic [31:0] m_rdata;
  logic [1:0]  m_rresp;
  logic        wr_acc;
  logic        rd_acc;
  logic [2:0]  slot;
  logic [3:0]  irq_clr;

  initial o_failed = 1'b0;

  // Slot 0..5 per word offset, 7 for unmapped or misaligned.
  function automatic logic [2:0] offset_slot(input logic [7:0] addr);
    if (addr[1:0] != 2'b00 || addr > 8'h14) return 3'd7;
    return addr[4:2];
  endfunction

  function automatic logic [31:0] model_read(input logic [2:0] s);
    case (s)
      3'd0: return {16'h0, m_ctrl};
      3'd1: return {16'h0, i_status};
      3'd2: return {28'h0, m_irq_st};
      3'd3: return {28'h0, m_irq_en};
      3'd4: return 32'h0;
      3'd5: return {24'h0, m_count};
      default: return regblk_map_pkg::DEFAULT_READ_DATA;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error: time %0t signal %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    o_failed = 1'b1;
  endtask

  assign wr_acc  = i_aw.valid && i_w.valid && i_awready && i_wready;
  assign rd_acc  = i_ar.valid && i_arready;
  assign slot    = offset_slot(wr_acc ? i_aw.addr : i_ar.addr);
  assign irq_clr = (wr_acc && slot == 3'd2) ? i_w.data[3:0] : 4'h0;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      m_ctrl   <= regblk_map_pkg::CTRL_RESET;
      m_irq_st <= '0;
      m_irq_en <= '0;
      m_cmd    <= '0;
      m_count  <= '0;
      m_bvalid <= 1'b0;
      m_rvalid <= 1'b0;
    end else begin
      if (wr_acc && slot == 3'd0 && i_w.strb[0]) m_ctrl[7:0] <= i_w.data[7:0];
      if (wr_acc && slot == 3'd0 && i_w.strb[1]) m_ctrl[15:8] <= i_w.data[15:8];
      if (wr_acc && slot == 3'd3 && i_w.strb[0]) m_irq_en <= i_w.data[3:0];
      m_irq_st <= (m_irq_st & ~irq_clr) | i_irq_set;  // Hardware set wins.
      m_cmd    <= (wr_acc && slot == 3'd4) ? i_w.data[3:0] : 4'h0;
      if (rd_acc && slot == 3'd5) m_count <= {7'h0, i_event};
      else if (i_event && m_count != 8'hFF) m_count <= m_count + 8'd1;
      if (m_bvalid && i_bready) m_bvalid <= 1'b0;
      if (m_rvalid && i_rready) m_rvalid <= 1'b0;
      if (wr_acc) begin
        m_bvalid <= 1'b1;
        m_bresp  <= (slot == 3'd7) ? regblk_bus_pkg::RESP_SLVERR : regblk_bus_pkg::RESP_OKAY;
      end
      if (rd_acc) begin
        m_rvalid <= 1'b1;
        m_rdata  <= model_read(slot);
        m_rresp  <= (slot == 3'd7) ? regblk_bus_pkg::RESP_SLVERR : regblk_bus_pkg::RESP_OKAY;
      end
    end
  end

  a_bvalid: assert property (@(posedge clk) disable iff (!i_rst_n) i_b.valid == m_bvalid)
    else report_mismatch("o_b.valid", 32'(m_bvalid), 32'(i_b.valid));
  a_bresp: assert property (@(posedge clk) disable iff (!i_rst_n) !m_bvalid || i_b.resp == m_bresp)
    else report_mismatch("o_b.resp", 32'(m_bresp), 32'(i_b.resp));
  a_rvalid: assert property (@(posedge clk) disable iff (!i_rst_n) i_r.valid == m_rvalid)
    else report_mismatch("o_r.valid", 32'(m_rvalid), 32'(i_r.valid));
  a_rdata: assert property (@(posedge clk) disable iff (!i_rst_n) !m_rvalid || i_r.data == m_rdata)
    else report_mismatch("o_r.data", m_rdata, i_r.data);
  a_rresp: assert property (@(posedge clk) disable iff (!i_rst_n) !m_rvalid || i_r.resp == m_rresp)
    else report_mismatch("o_r.resp", 32'(m_rresp), 32'(i_r.resp));
  a_ctrl: assert property (@(posedge clk) disable iff (!i_rst_n) i_ctrl == m_ctrl)
    else report_mismatch("o_ctrl", 32'(m_ctrl), 32'(i_ctrl));
  a_irq: assert property (@(posedge clk) disable iff (!i_rst_n) i_irq == |(m_irq_st & m_irq_en))
    else report_mismatch("o_irq", 32'(|(m_irq_st & m_irq_en)), 32'(i_irq));
  a_cmd: assert property (@(posedge clk) disable iff (!i_rst_n) i_cmd_trigger == m_cmd)
    else report_mismatch("o_cmd_trigger", 32'(m_cmd), 32'(i_cmd_trigger));

  // One transaction in flight.
  a_no_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(m_bvalid || m_rvalid) || !(i_awready || i_wready || i_arready))
  else begin
    $display("A request ready rose while a response was pending at time %0t.", $time);
    o_failed = 1'b1;
  end

endmodule

/* design/regblk_top.sv */
module regblk_top (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  regblk_bus_pkg::aw_t     i_aw,
  input  regblk_bus_pkg::w_t      i_w,
  input  regblk_bus_pkg::ar_t     i_ar,
  input  logic                    i_bready,
  input  logic                    i_rready,
  output logic                    o_awready,
  output logic                    o_wready,
  output logic                    o_arready,
  output regblk_bus_pkg::b_t      o_b,
  output regblk_bus_pkg::r_t      o_r,
  input  regblk_map_pkg::status_t i_status,
  input  regblk_map_pkg::irq_t    i_irq_set,
  input  logic                    i_event,
  output regblk_map_pkg::ctrl_t   o_ctrl,
  output logic                    o_irq,
  output regblk_map_pkg::cmd_t    o_cmd_trigger
);

  regblk_map_pkg::access_t access;
  regblk_bus_pkg::data_t   rdata;
  logic                    busy;

  regblk_decode u_decode (
    .clk       (clk      ),
    .i_rst_n   (i_rst_n  ),
    .i_aw      (i_aw     ),
    .i_w       (i_w      ),
    .i_ar      (i_ar     ),
    .i_busy    (busy     ),
    .o_awready (o_awready),
    .o_wready  (o_wready ),
    .o_arready (o_arready),
    .o_access  (access   )
  );

  regblk_fields u_fields (
    .clk           (clk          ),
    .i_rst_n       (i_rst_n      ),
    .i_access      (access       ),
    .i_status      (i_status     ),
    .i_irq_set     (i_irq_set    ),
    .i_event       (i_event      ),
    .o_rdata       (rdata        ),
    .o_ctrl        (o_ctrl       ),
    .o_irq         (o_irq        ),
    .o_cmd_trigger (o_cmd_trigger)
  );

  regblk_result u_result (
    .clk      (clk     ),
    .i_rst_n  (i_rst_n ),
    .i_access (access  ),
    .i_rdata  (rdata   ),
    .i_bready (i_bready),
    .i_rready (i_rready),
    .o_b      (o_b     ),
    .o_r      (o_r     ),
    .o_busy   (busy    )
  );

endmodule

/* design/regblk_result.sv */
module regblk_result (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  regblk_map_pkg::access_t i_access,
  input  regblk_bus_pkg::data_t   i_rdata,
  input  logic                    i_bready,
  input  logic                    i_rready,
  output regblk_bus_pkg::b_t      o_b,
  output regblk_bus_pkg::r_t      o_r,
  output logic                    o_busy
);

  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_WRITE,
    RESP_READ
  } state_e;

  state_e                state_q;
  regblk_bus_pkg::resp_t resp_q;
  regblk_bus_pkg::data_t rdata_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q <= RESP_IDLE;
    end else begin
      case (state_q)
        RESP_IDLE: begin
          if (i_access.valid) begin
            state_q <= i_access.write ? RESP_WRITE : RESP_READ;
          end
        end
        RESP_WRITE: begin
          if (i_bready) state_q <= RESP_IDLE;
        end
        RESP_READ: begin
          if (i_rready) state_q <= RESP_IDLE;
        end
        default: state_q <= RESP_IDLE;
      endcase
    end
  end

  // Response payload, captured at acceptance.
  always_ff @(posedge clk) begin
    if ((state_q == RESP_IDLE) && i_access.valid) begin
      resp_q  <= i_access.err ? regblk_bus_pkg::RESP_SLVERR : regblk_bus_pkg::RESP_OKAY;
      rdata_q <= i_rdata;
    end
  end

  assign o_b.valid = (state_q == RESP_WRITE);
  assign o_b.resp  = resp_q;
  assign o_r.valid = (state_q == RESP_READ);
  assign o_r.data  = rdata_q;
  assign o_r.resp  = resp_q;

  assign o_busy = (state_q != RESP_IDLE);

  a_b_hold: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (o_b.valid && !i_bready) |=> $stable(o_b)
  );

  a_r_hold: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (o_r.valid && !i_rready) |=> $stable(o_r)
  );

endmodule

/* design/regblk_fields.sv */
module regblk_fields (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  regblk_map_pkg::access_t i_access,
  input  regblk_map_pkg::status_t i_status,
  input  regblk_map_pkg::irq_t    i_irq_set,
  input  logic                    i_event,
  output regblk_bus_pkg::data_t   o_rdata,
  output regblk_map_pkg::ctrl_t   o_ctrl,
  output logic                    o_irq,
  output regblk_map_pkg::cmd_t    o_cmd_trigger
);

  regblk_map_pkg::ctrl_t  ctrl_q;
  regblk_map_pkg::irq_t   irq_status_q;
  regblk_map_pkg::irq_t   irq_enable_q;
  regblk_map_pkg::irq_t   irq_clear;
  regblk_map_pkg::cmd_t   cmd_q;
  regblk_map_pkg::count_t count_q;
  logic                   wr_hit;
  logic                   rd_hit;
  logic                   wr_ctrl;
  logic                   wr_irq_status;
  logic                   wr_irq_enable;
  logic                   wr_command;
  logic                   rd_count;

  assign wr_hit = i_access.valid && i_access.write && !i_access.err;
  assign rd_hit = i_access.valid && !i_access.write && !i_access.err;

  assign wr_ctrl       = wr_hit && (i_access.index == regblk_map_pkg::REG_CTRL);
  assign wr_irq_status = wr_hit && (i_access.index == regblk_map_pkg::REG_IRQ_STATUS);
  assign wr_irq_enable = wr_hit && (i_access.index == regblk_map_pkg::REG_IRQ_ENABLE);
  assign wr_command    = wr_hit && (i_access.index == regblk_map_pkg::REG_COMMAND);
  assign rd_count      = rd_hit && (i_access.index == regblk_map_pkg::REG_EVENT_COUNT);

  // CTRL, byte strobed.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ctrl_q <= regblk_map_pkg::CTRL_RESET;
    end else if (wr_ctrl) begin
      for (int b = 0; b < $bits(regblk_map_pkg::ctrl_t) / 8; b++) begin
        if (i_access.strb[b]) begin
          ctrl_q[b*8 +: 8] <= i_access.wdata[b*8 +: 8];
        end
      end
    end
  end

  // IRQ_ENABLE lives in byte 0.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      irq_enable_q <= '0;
    end else if (wr_irq_enable && i_access.strb[0]) begin
      irq_enable_q <= regblk_map_pkg::irq_t'(i_access.wdata);
    end
  end

  assign irq_clear = wr_irq_status ? regblk_map_pkg::irq_t'(i_access.wdata) : '0;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      irq_status_q <= '0;
    end else begin
      irq_status_q <= (irq_status_q & ~irq_clear) | i_irq_set;  // Set wins.
    end
  end

  // Trigger lasts one cycle.
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cmd_q <= '0;
    end else begin
      cmd_q <= wr_command ? regblk_map_pkg::cmd_t'(i_access.wdata) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      count_q <= '0;
    end else if (rd_count) begin
      count_q <= regblk_map_pkg::count_t'(i_event);  // Clear, keep a coincident event.
    end else if (i_event && (count_q != '1)) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    o_rdata = regblk_map_pkg::DEFAULT_READ_DATA;
    if (!i_access.err) begin
      case (i_access.index)
        regblk_map_pkg::REG_CTRL:        o_rdata = regblk_bus_pkg::data_t'(ctrl_q);
        regblk_map_pkg::REG_STATUS:      o_rdata = regblk_bus_pkg::data_t'(i_status);
        regblk_map_pkg::REG_IRQ_STATUS:  o_rdata = regblk_bus_pkg::data_t'(irq_status_q);
        regblk_map_pkg::REG_IRQ_ENABLE:  o_rdata = regblk_bus_pkg::data_t'(irq_enable_q);
        regblk_map_pkg::REG_COMMAND:     o_rdata = '0;  // Write only.
        regblk_map_pkg::REG_EVENT_COUNT: o_rdata = regblk_bus_pkg::data_t'(count_q);
        default: begin
          o_rdata = regblk_map_pkg::DEFAULT_READ_DATA;
        end
      endcase
    end
  end

  assign o_ctrl        = ctrl_q;
  assign o_irq         = |(irq_status_q & irq_enable_q);
  assign o_cmd_trigger = cmd_q;

  // A trigger only follows an accepted COMMAND write.
  a_cmd_pulse: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (o_cmd_trigger != '0) |-> $past(wr_command)
  );

endmodule

/* design/regblk_decode.sv */
module regblk_decode (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  regblk_bus_pkg::aw_t     i_aw,
  input  regblk_bus_pkg::w_t      i_w,
  input  regblk_bus_pkg::ar_t     i_ar,
  input  logic                    i_busy,
  output logic                    o_awready,
  output logic                    o_wready,
  output logic                    o_arready,
  output regblk_map_pkg::access_t o_access
);

  logic                     wr_req;
  logic                     wr_fire;
  logic                     rd_fire;
  regblk_bus_pkg::addr_t    addr;
  regblk_map_pkg::reg_idx_e index;

  // Address and data must both be present for a write.
  assign wr_req  = i_aw.valid && i_w.valid;
  assign wr_fire = wr_req && !i_busy;
  assign rd_fire = i_ar.valid && !wr_req && !i_busy;  // Write has priority.

  assign o_awready = wr_fire;
  assign o_wready  = wr_fire;
  assign o_arready = rd_fire;

  assign addr = wr_fire ? i_aw.addr : i_ar.addr;

  // Word offset to register index.
  always_comb begin
    case ({addr[7:2], 2'b00})
      regblk_map_pkg::OFS_CTRL: begin
        index = regblk_map_pkg::REG_CTRL;
      end
      regblk_map_pkg::OFS_STATUS: begin
        index = regblk_map_pkg::REG_STATUS;
      end
      regblk_map_pkg::OFS_IRQ_STATUS: begin
        index = regblk_map_pkg::REG_IRQ_STATUS;
      end
      regblk_map_pkg::OFS_IRQ_ENABLE: begin
        index = regblk_map_pkg::REG_IRQ_ENABLE;
      end
      regblk_map_pkg::OFS_COMMAND: begin
        index = regblk_map_pkg::REG_COMMAND;
      end
      regblk_map_pkg::OFS_EVENT_COUNT: begin
        index = regblk_map_pkg::REG_EVENT_COUNT;
      end
      default: begin
        index = regblk_map_pkg::REG_NONE;
      end
    endcase
  end

  always_comb begin
    o_access.valid = wr_fire || rd_fire;
    o_access.write = wr_fire;
    o_access.index = index;
    o_access.wdata = i_w.data;
    o_access.strb  = i_w.strb;
    o_access.err   = (index == regblk_map_pkg::REG_NONE) || (addr[1:0] != 2'b00);
  end

  // Only one channel may be accepted per cycle.
  a_one_grant: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    !((o_awready || o_wready) && o_arready)
  );

endmodule

/* design/regblk_map_pkg.sv */
package regblk_map_pkg;

  typedef enum logic [2:0] {
    REG_CTRL,
    REG_STATUS,
    REG_IRQ_STATUS,
    REG_IRQ_ENABLE,
    REG_COMMAND,
    REG_EVENT_COUNT,
    REG_NONE
  } reg_idx_e;

  // Word offsets of the register map.
  localparam regblk_bus_pkg::addr_t OFS_CTRL        = 8'h00;
  localparam regblk_bus_pkg::addr_t OFS_STATUS      = 8'h04;
  localparam regblk_bus_pkg::addr_t OFS_IRQ_STATUS  = 8'h08;
  localparam regblk_bus_pkg::addr_t OFS_IRQ_ENABLE  = 8'h0C;
  localparam regblk_bus_pkg::addr_t OFS_COMMAND     = 8'h10;
  localparam regblk_bus_pkg::addr_t OFS_EVENT_COUNT = 8'h14;

  typedef logic [15:0] ctrl_t;
  typedef logic [15:0] status_t;
  typedef logic [3:0]  irq_t;
  typedef logic [3:0]  cmd_t;
  typedef logic [7:0]  count_t;  // Saturating event counter.

  localparam ctrl_t CTRL_RESET = 16'h0005;

  localparam regblk_bus_pkg::data_t DEFAULT_READ_DATA = 32'hDEAD_BEAF;

  // One decoded register access.
  typedef struct packed {
    logic                  valid;
    logic                  write;
    reg_idx_e              index;
    regblk_bus_pkg::data_t wdata;
    regblk_bus_pkg::strb_t strb;
    logic                  err;    // Unmapped or misaligned.
  } access_t;

endpackage

/* design/regblk_bus_pkg.sv */
package regblk_bus_pkg;

  // Bus word sizes.
  typedef logic [7:0]  addr_t;  // Byte offset.
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Write address channel.
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } aw_t;

  // Write data channel.
  typedef struct packed {
    logic  valid;
    data_t data;
    strb_t strb;
  } w_t;

  // Write response channel.
  typedef struct packed {
    logic  valid;
    resp_t resp;
  } b_t;

  // Read address channel.
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } ar_t;

  // Read data channel.
  typedef struct packed {
    logic  valid;
    data_t data;
    resp_t resp;
  } r_t;

endpackage
